// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - include_dirs:
      - .
    files:
      - ex_pkg.sv
      - ex_alu.sv
      - ex_multdiv_slow.sv
      - ex_block.sv
      - ex_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - ex_stage_props.sv
      - ex_stage_tb.sv

// ==== ex_alu.sv ====
////////////////////////////////////////
// Single-cycle ALU
// Shared adder, logic, shifts and compares
////////////////////////////////////////

`timescale 1ns/1ps

`include "ex_macros.svh"

module ex_alu (
  input  ex_pkg::alu_op_e   operator_i,
  input  logic [`XLEN-1:0]  operand_a_i,
  input  logic [`XLEN-1:0]  operand_b_i,

  // Adder borrowed by the multiply/divide unit
  input  logic [`XLEN:0]    multdiv_operand_a_i,
  input  logic [`XLEN:0]    multdiv_operand_b_i,
  input  logic              multdiv_sel_i,

  output logic [`XLEN-1:0]  adder_result_o,
  output logic [`XLEN+1:0]  adder_result_ext_o,
  output logic [`XLEN-1:0]  result_o,
  output logic              comparison_result_o,
  output logic              is_equal_result_o
);

  logic              adder_op_b_negate;
  logic              cmp_signed;
  logic [`XLEN:0]    adder_in_a;
  logic [`XLEN:0]    adder_in_b;
  logic [`XLEN+1:0]  adder_result_ext;
  logic [`XLEN-1:0]  adder_result;
  logic              is_equal;
  logic              is_greater_equal;
  logic              cmp_result;
  logic [4:0]        shift_amt;

  ////////////////////////////////////////
  // Adder
  ////////////////////////////////////////

  always_comb begin
    adder_op_b_negate = 1'b0;
    cmp_signed        = 1'b0;
    case (operator_i)
      ex_pkg::SUB, ex_pkg::EQ, ex_pkg::NE, ex_pkg::LTU, ex_pkg::GEU, ex_pkg::SLTU: begin
        adder_op_b_negate = 1'b1;
      end
      ex_pkg::LT, ex_pkg::GE, ex_pkg::SLT: begin
        adder_op_b_negate = 1'b1;
        cmp_signed        = 1'b1;
      end
      default: ;
    endcase
  end

  // Extra LSB carries the +1 of the two's complement negation
  assign adder_in_a = multdiv_sel_i ? multdiv_operand_a_i : {operand_a_i, 1'b1};
  assign adder_in_b = multdiv_sel_i ? multdiv_operand_b_i :
                      ({operand_b_i, 1'b0} ^ {(`XLEN+1){adder_op_b_negate}});

  assign adder_result_ext = {1'b0, adder_in_a} + {1'b0, adder_in_b};
  assign adder_result     = adder_result_ext[`XLEN:1];

  assign adder_result_o     = adder_result;
  assign adder_result_ext_o = adder_result_ext;

  ////////////////////////////////////////
  // Comparisons
  ////////////////////////////////////////

  assign is_equal = (adder_result == '0);

  // Same signs: the difference decides; otherwise the MSB of a does
  always_comb begin
    if ((operand_a_i[`XLEN-1] ^ operand_b_i[`XLEN-1]) == 1'b0) begin
      is_greater_equal = ~adder_result[`XLEN-1];
    end else begin
      is_greater_equal = operand_a_i[`XLEN-1] ^ cmp_signed;
    end
  end

  always_comb begin
    case (operator_i)
      ex_pkg::EQ:                                       cmp_result = is_equal;
      ex_pkg::NE:                                       cmp_result = ~is_equal;
      ex_pkg::GE, ex_pkg::GEU:                          cmp_result = is_greater_equal;
      ex_pkg::LT, ex_pkg::LTU, ex_pkg::SLT, ex_pkg::SLTU: cmp_result = ~is_greater_equal;
      default:                                          cmp_result = 1'b0;
    endcase
  end

  assign comparison_result_o = cmp_result;
  assign is_equal_result_o   = is_equal;

  ////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////

  assign shift_amt = operand_b_i[4:0];

  always_comb begin
    case (operator_i)
      ex_pkg::ADD, ex_pkg::SUB: result_o = adder_result;
      ex_pkg::XOR:              result_o = operand_a_i ^ operand_b_i;
      ex_pkg::OR:               result_o = operand_a_i | operand_b_i;
      ex_pkg::AND:              result_o = operand_a_i & operand_b_i;
      ex_pkg::SLL:              result_o = operand_a_i << shift_amt;
      ex_pkg::SRL:              result_o = operand_a_i >> shift_amt;
      ex_pkg::SRA:              result_o = $unsigned($signed(operand_a_i) >>> shift_amt);
      // SLT, SLTU and branch compares
      default:                  result_o = {{(`XLEN-1){1'b0}}, cmp_result};
    endcase
  end

endmodule

// ==== ex_block.sv ====
////////////////////////////////////////
// Execution block
// ALU plus multiply/divide unit, result
// select and branch outputs
////////////////////////////////////////

`timescale 1ns/1ps

`include "ex_macros.svh"

module ex_block #(
  parameter bit branch_target_alu = 1'b0
) (
  input  logic               clk_i,
  input  logic               reset_i,

  // ALU
  input  ex_pkg::alu_op_e    alu_operator_i,
  input  logic [`XLEN-1:0]   alu_operand_a_i,
  input  logic [`XLEN-1:0]   alu_operand_b_i,

  // Branch target operands, only with the dedicated adder
  input  logic [`XLEN-1:0]   bt_a_operand_i,
  input  logic [`XLEN-1:0]   bt_b_operand_i,

  // Multiply/divide
  input  ex_pkg::md_op_e     multdiv_operator_i,
  input  logic               mult_en_i,
  input  logic               div_en_i,
  input  logic               mult_sel_i,
  input  logic               div_sel_i,
  input  logic [`XLEN-1:0]   multdiv_operand_a_i,
  input  logic [`XLEN-1:0]   multdiv_operand_b_i,
  input  logic               multdiv_ready_id_i,

  // Intermediate value registers
  input  logic [`IMD_W-1:0]  imd_val_q_i[2],
  output logic [1:0]         imd_val_we_o,
  output logic [`IMD_W-1:0]  imd_val_d_o[2],

  output logic [`XLEN-1:0]   alu_adder_result_o,
  output logic [`XLEN-1:0]   result_o,
  output logic [`XLEN-1:0]   branch_target_o,
  output logic               branch_decision_o,
  output logic               ex_valid_o
);

  logic [`XLEN-1:0]  alu_result;
  logic [`XLEN-1:0]  multdiv_result;
  logic [`XLEN:0]    multdiv_alu_operand_a;
  logic [`XLEN:0]    multdiv_alu_operand_b;
  logic [`XLEN+1:0]  alu_adder_result_ext;
  logic              alu_cmp_result;
  logic              alu_is_equal_result;
  logic              multdiv_valid;
  logic              multdiv_sel;

  assign multdiv_sel = mult_sel_i | div_sel_i;

  assign result_o          = multdiv_sel ? multdiv_result : alu_result;
  assign branch_decision_o = alu_cmp_result;

  // ALU operations finish in the same cycle
  assign ex_valid_o = multdiv_sel ? multdiv_valid : 1'b1;

  if (branch_target_alu) begin : g_bt_adder
    assign branch_target_o = bt_a_operand_i + bt_b_operand_i;
  end else begin : g_bt_shared
    assign branch_target_o = alu_adder_result_o;
  end

  ex_alu u_alu (
    .operator_i          (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .multdiv_operand_a_i (multdiv_alu_operand_a),
    .multdiv_operand_b_i (multdiv_alu_operand_b),
    .multdiv_sel_i       (multdiv_sel),
    .adder_result_o      (alu_adder_result_o),
    .adder_result_ext_o  (alu_adder_result_ext),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp_result),
    .is_equal_result_o   (alu_is_equal_result)
  );

  ex_multdiv_slow u_multdiv (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .mult_en_i          (mult_en_i),
    .div_en_i           (div_en_i),
    .mult_sel_i         (mult_sel_i),
    .div_sel_i          (div_sel_i),
    .operator_i         (multdiv_operator_i),
    .op_a_i             (multdiv_operand_a_i),
    .op_b_i             (multdiv_operand_b_i),
    .alu_adder_ext_i    (alu_adder_result_ext),
    .equal_to_zero_i    (alu_is_equal_result),
    .imd_val_q_i        (imd_val_q_i),
    .multdiv_ready_id_i (multdiv_ready_id_i),
    .alu_operand_a_o    (multdiv_alu_operand_a),
    .alu_operand_b_o    (multdiv_alu_operand_b),
    .imd_val_d_o        (imd_val_d_o),
    .imd_val_we_o       (imd_val_we_o),
    .valid_o            (multdiv_valid),
    .multdiv_result_o   (multdiv_result)
  );

endmodule

// ==== ex_macros.svh ====
////////////////////////////////////////
// Execution stage sizing macros
// Word width, intermediate register width
// and multiply/divide iteration count
////////////////////////////////////////

`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// Data word
`define XLEN 32

// Each intermediate value register, two bits wider than a word
`define IMD_W 34

// One step per operand bit
`define MD_STEPS 32

`endif

// ==== ex_multdiv_slow.sv ====
////////////////////////////////////////
// Iterative unsigned multiply/divide
// Shift-add multiply, restoring divide,
// one bit per cycle on the ALU adder
////////////////////////////////////////

`timescale 1ns/1ps

`include "ex_macros.svh"

module ex_multdiv_slow (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               mult_en_i,
  input  logic               div_en_i,
  input  logic               mult_sel_i,
  input  logic               div_sel_i,
  input  ex_pkg::md_op_e     operator_i,
  input  logic [`XLEN-1:0]   op_a_i,
  input  logic [`XLEN-1:0]   op_b_i,
  input  logic [`XLEN+1:0]   alu_adder_ext_i,
  input  logic               equal_to_zero_i,
  input  logic [`IMD_W-1:0]  imd_val_q_i[2],
  input  logic               multdiv_ready_id_i,
  output logic [`XLEN:0]     alu_operand_a_o,
  output logic [`XLEN:0]     alu_operand_b_o,
  output logic [`IMD_W-1:0]  imd_val_d_o[2],
  output logic [1:0]         imd_val_we_o,
  output logic               valid_o,
  output logic [`XLEN-1:0]   multdiv_result_o
);

  typedef enum logic [1:0] {
    MD_IDLE,
    MD_LOAD,
    MD_STEP,
    MD_FINISH
  } md_state_e;

  md_state_e         state_q, state_d;
  logic [4:0]        step_cnt_q, step_cnt_d;
  logic              div_zero_q, div_zero_d;
  logic              md_en;
  logic              md_sel;
  logic [`XLEN-1:0]  hi_q;
  logic [`XLEN-1:0]  lo_q;
  logic [`XLEN:0]    rem_shift;
  logic              div_keep;

  assign md_en  = mult_en_i | div_en_i;
  assign md_sel = mult_sel_i | div_sel_i;

  // Slot 0 holds product high half or remainder, slot 1 low half or quotient
  assign hi_q = imd_val_q_i[0][`XLEN-1:0];
  assign lo_q = imd_val_q_i[1][`XLEN-1:0];

  // Partial remainder with the next dividend bit shifted in
  assign rem_shift = {hi_q, lo_q[`XLEN-1]};

  // Keep the difference when it cannot be negative
  assign div_keep = rem_shift[`XLEN] | alu_adder_ext_i[`XLEN+1];

  ////////////////////////////////////////
  // Adder operands
  ////////////////////////////////////////

  always_comb begin
    // Outside the steps the adder passes the divisor for the zero check
    alu_operand_a_o = {op_b_i, 1'b0};
    alu_operand_b_o = '0;
    if (state_q == MD_STEP) begin
      if (div_sel_i) begin
        alu_operand_a_o = {rem_shift[`XLEN-1:0], 1'b1};
        alu_operand_b_o = {~op_b_i, 1'b1};
      end else begin
        alu_operand_a_o = {hi_q, 1'b0};
        alu_operand_b_o = lo_q[0] ? {op_a_i, 1'b0} : '0;
      end
    end
  end

  ////////////////////////////////////////
  // Intermediate register updates
  ////////////////////////////////////////

  always_comb begin
    imd_val_d_o[0] = '0;
    imd_val_d_o[1] = '0;
    imd_val_we_o   = 2'b00;
    case (state_q)
      MD_LOAD: begin
        imd_val_we_o = 2'b11;
        if (div_sel_i && equal_to_zero_i) begin
          // Zero divisor, final values loaded up front
          imd_val_d_o[0] = {2'b00, op_a_i};
          imd_val_d_o[1] = {2'b00, {`XLEN{1'b1}}};
        end else if (div_sel_i) begin
          imd_val_d_o[1] = {2'b00, op_a_i};
        end else begin
          imd_val_d_o[1] = {2'b00, op_b_i};
        end
      end
      MD_STEP: begin
        if (div_sel_i) begin
          imd_val_we_o   = {2{~div_zero_q}};
          imd_val_d_o[0] = {2'b00, div_keep ? alu_adder_ext_i[`XLEN:1] : rem_shift[`XLEN-1:0]};
          imd_val_d_o[1] = {2'b00, lo_q[`XLEN-2:0], div_keep};
        end else begin
          // 33-bit sum shifted right into the product pair
          imd_val_we_o   = 2'b11;
          imd_val_d_o[0] = {2'b00, alu_adder_ext_i[`XLEN+1:2]};
          imd_val_d_o[1] = {2'b00, alu_adder_ext_i[1], lo_q[`XLEN-1:1]};
        end
      end
      default: ;
    endcase
    if (!md_sel) begin
      imd_val_we_o = 2'b00;
    end
  end

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    step_cnt_d = step_cnt_q;
    div_zero_d = div_zero_q;
    case (state_q)
      MD_IDLE: begin
        if (md_en) begin
          state_d = MD_LOAD;
        end
      end
      MD_LOAD: begin
        step_cnt_d = 5'(`MD_STEPS - 1);
        div_zero_d = div_sel_i & equal_to_zero_i;
        state_d    = MD_STEP;
      end
      MD_STEP: begin
        step_cnt_d = step_cnt_q - 5'd1;
        if (step_cnt_q == 5'd0) begin
          state_d = MD_FINISH;
        end
      end
      MD_FINISH: begin
        // Hold the result until the issue side takes it
        if (multdiv_ready_id_i) begin
          state_d = MD_IDLE;
        end
      end
      default: state_d = MD_IDLE;
    endcase
    // Dropped enables abandon an operation in flight
    if (!md_en && (state_q == MD_LOAD || state_q == MD_STEP)) begin
      state_d = MD_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= MD_IDLE;
      step_cnt_q <= '0;
      div_zero_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      step_cnt_q <= step_cnt_d;
      div_zero_q <= div_zero_d;
    end
  end

  assign valid_o = (state_q == MD_FINISH);

  always_comb begin
    case (operator_i)
      ex_pkg::MD_MULH, ex_pkg::MD_REM: multdiv_result_o = hi_q;
      default:                         multdiv_result_o = lo_q;
    endcase
  end

endmodule

// ==== ex_pkg.sv ====
////////////////////////////////////////
// Execution stage package
// Operator encodings for the ALU and the
// multiply/divide unit
////////////////////////////////////////

package ex_pkg;

  // ALU operators
  typedef enum logic [4:0] {
    // Arithmetic
    ADD,
    SUB,
    // Bitwise logic
    XOR,
    OR,
    AND,
    // Shifts
    SLL,
    SRL,
    SRA,
    // Set-less-than, result written as 0 or 1
    SLT,
    SLTU,
    // Branch comparisons
    EQ,
    NE,
    LT,
    GE,
    LTU,
    GEU
  } alu_op_e;

  // Multiply/divide operators, all unsigned
  typedef enum logic [1:0] {
    MD_MUL,
    MD_MULH,
    MD_DIV,
    MD_REM
  } md_op_e;

endpackage

// ==== ex_stage.sv ====
////////////////////////////////////////
// Execution stage top level
// Execution block and intermediate
// value registers
////////////////////////////////////////

`timescale 1ns/1ps

`include "ex_macros.svh"

module ex_stage #(
  parameter bit branch_target_alu = 1'b0
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  ex_pkg::alu_op_e   alu_operator_i,
  input  logic [`XLEN-1:0]  alu_operand_a_i,
  input  logic [`XLEN-1:0]  alu_operand_b_i,
  input  logic [`XLEN-1:0]  bt_a_operand_i,
  input  logic [`XLEN-1:0]  bt_b_operand_i,
  input  ex_pkg::md_op_e    multdiv_operator_i,
  input  logic              mult_en_i,
  input  logic              div_en_i,
  input  logic              mult_sel_i,
  input  logic              div_sel_i,
  input  logic [`XLEN-1:0]  multdiv_operand_a_i,
  input  logic [`XLEN-1:0]  multdiv_operand_b_i,
  input  logic              multdiv_ready_id_i,
  output logic [`XLEN-1:0]  alu_adder_result_o,
  output logic [`XLEN-1:0]  result_o,
  output logic [`XLEN-1:0]  branch_target_o,
  output logic              branch_decision_o,
  output logic              ex_valid_o
);

  logic [`IMD_W-1:0]  imd_val_q[2];
  logic [`IMD_W-1:0]  imd_val_d[2];
  logic [1:0]         imd_val_we;

  // Intermediate value registers, written per slot
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      imd_val_q[0] <= '0;
      imd_val_q[1] <= '0;
    end else begin
      if (imd_val_we[0]) begin
        imd_val_q[0] <= imd_val_d[0];
      end
      if (imd_val_we[1]) begin
        imd_val_q[1] <= imd_val_d[1];
      end
    end
  end

  ex_block #(
    .branch_target_alu (branch_target_alu)
  ) u_ex_block (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .alu_operator_i      (alu_operator_i),
    .alu_operand_a_i     (alu_operand_a_i),
    .alu_operand_b_i     (alu_operand_b_i),
    .bt_a_operand_i      (bt_a_operand_i),
    .bt_b_operand_i      (bt_b_operand_i),
    .multdiv_operator_i  (multdiv_operator_i),
    .mult_en_i           (mult_en_i),
    .div_en_i            (div_en_i),
    .mult_sel_i          (mult_sel_i),
    .div_sel_i           (div_sel_i),
    .multdiv_operand_a_i (multdiv_operand_a_i),
    .multdiv_operand_b_i (multdiv_operand_b_i),
    .multdiv_ready_id_i  (multdiv_ready_id_i),
    .imd_val_q_i         (imd_val_q),
    .imd_val_we_o        (imd_val_we),
    .imd_val_d_o         (imd_val_d),
    .alu_adder_result_o  (alu_adder_result_o),
    .result_o            (result_o),
    .branch_target_o     (branch_target_o),
    .branch_decision_o   (branch_decision_o),
    .ex_valid_o          (ex_valid_o)
  );

endmodule

// ==== ex_stage_props.sv ====
////////////////////////////////////////
// Execution stage assertions
// Handshake and register write checks
////////////////////////////////////////

`timescale 1ns/1ps

`include "ex_macros.svh"

module ex_stage_props (
  input logic              clk_i,
  input logic              reset_i,
  input logic              mult_en_i,
  input logic              div_en_i,
  input logic              mult_sel_i,
  input logic              div_sel_i,
  input logic              multdiv_ready_id_i,
  input logic              ex_valid_o,
  input logic [`XLEN-1:0]  result_o,
  input logic [1:0]        imd_val_we_i
);

  logic md_sel;
  logic md_en;

  // Set once any property below fails
  logic assert_failed = 1'b0;

  assign md_sel = mult_sel_i | div_sel_i;
  assign md_en  = mult_en_i | div_en_i;

  // No intermediate writes for ALU-only work or while a result waits
  imd_we_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    (!md_sel || ex_valid_o) |-> (imd_val_we_i == 2'b00))
    else begin
      $error("Intermediate register write outside a multiply/divide step");
      assert_failed = 1'b1;
    end

  // Held result under back-pressure
  result_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (md_sel && ex_valid_o && !multdiv_ready_id_i) |=> $stable(result_o))
    else begin
      $error("Result changed while waiting for ready");
      assert_failed = 1'b1;
    end

  valid_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(md_en) |-> ##[1:(`MD_STEPS + 2)] ex_valid_o)
    else begin
      $error("Multiply/divide did not complete in time");
      assert_failed = 1'b1;
    end

endmodule

bind ex_stage ex_stage_props u_props (
  .clk_i              (clk_i),
  .reset_i            (reset_i),
  .mult_en_i          (mult_en_i),
  .div_en_i           (div_en_i),
  .mult_sel_i         (mult_sel_i),
  .div_sel_i          (div_sel_i),
  .multdiv_ready_id_i (multdiv_ready_id_i),
  .ex_valid_o         (ex_valid_o),
  .result_o           (result_o),
  .imd_val_we_i       (imd_val_we)
);

// ==== ex_stage_tb.sv ====
////////////////////////////////////////
// Execution stage testbench
// Random ALU and multiply/divide stimulus
// checked against a reference model
////////////////////////////////////////

`timescale 1ns/1ps

`include "ex_macros.svh"

module ex_stage_tb;

  localparam int CYCLE_LIMIT = 12000;
  localparam int ALU_TESTS   = 300;
  localparam int MD_TESTS    = 200;
  localparam int MD_LATENCY  = `MD_STEPS + 2;

  logic              clk_i;
  logic              reset_i;
  ex_pkg::alu_op_e   alu_operator_i;
  logic [`XLEN-1:0]  alu_operand_a_i;
  logic [`XLEN-1:0]  alu_operand_b_i;
  logic [`XLEN-1:0]  bt_a_operand_i;
  logic [`XLEN-1:0]  bt_b_operand_i;
  ex_pkg::md_op_e    multdiv_operator_i;
  logic              mult_en_i;
  logic              div_en_i;
  logic              mult_sel_i;
  logic              div_sel_i;
  logic [`XLEN-1:0]  multdiv_operand_a_i;
  logic [`XLEN-1:0]  multdiv_operand_b_i;
  logic              multdiv_ready_id_i;
  logic [`XLEN-1:0]  alu_adder_result_o;
  logic [`XLEN-1:0]  result_o;
  logic [`XLEN-1:0]  branch_target_o;
  logic              branch_decision_o;
  logic              ex_valid_o;

  logic [31:0]       rng_state = 32'd38990;
  int                cycle_cnt = 0;

  // Expected values for the comparing process
  logic              alu_chk;
  logic              md_chk;
  logic              chk_adder;
  logic              chk_branch;
  logic              exp_branch;
  logic [`XLEN-1:0]  exp_result;
  logic [`XLEN-1:0]  exp_adder;
  logic [`XLEN-1:0]  exp_target;

  ex_stage #(
    .branch_target_alu (1'b1)
  ) uut (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .alu_operator_i      (alu_operator_i),
    .alu_operand_a_i     (alu_operand_a_i),
    .alu_operand_b_i     (alu_operand_b_i),
    .bt_a_operand_i      (bt_a_operand_i),
    .bt_b_operand_i      (bt_b_operand_i),
    .multdiv_operator_i  (multdiv_operator_i),
    .mult_en_i           (mult_en_i),
    .div_en_i            (div_en_i),
    .mult_sel_i          (mult_sel_i),
    .div_sel_i           (div_sel_i),
    .multdiv_operand_a_i (multdiv_operand_a_i),
    .multdiv_operand_b_i (multdiv_operand_b_i),
    .multdiv_ready_id_i  (multdiv_ready_id_i),
    .alu_adder_result_o  (alu_adder_result_o),
    .result_o            (result_o),
    .branch_target_o     (branch_target_o),
    .branch_decision_o   (branch_decision_o),
    .ex_valid_o          (ex_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Helpers and reference model
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [`XLEN-1:0] alu_ref(input ex_pkg::alu_op_e op,
                                               input logic [`XLEN-1:0] a,
                                               input logic [`XLEN-1:0] b);
    case (op)
      ex_pkg::ADD:               return a + b;
      ex_pkg::SUB:               return a - b;
      ex_pkg::XOR:               return a ^ b;
      ex_pkg::OR:                return a | b;
      ex_pkg::AND:               return a & b;
      ex_pkg::SLL:               return a << b[4:0];
      ex_pkg::SRL:               return a >> b[4:0];
      // Vacated upper bits take the sign of a
      ex_pkg::SRA:               return (a >> b[4:0]) |
                                        ({`XLEN{a[`XLEN-1]}} & ~({`XLEN{1'b1}} >> b[4:0]));
      ex_pkg::SLT, ex_pkg::LT:   return `XLEN'($signed(a) < $signed(b));
      ex_pkg::SLTU, ex_pkg::LTU: return `XLEN'(a < b);
      ex_pkg::EQ:                return `XLEN'(a == b);
      ex_pkg::NE:                return `XLEN'(a != b);
      ex_pkg::GE:                return `XLEN'($signed(a) >= $signed(b));
      default:                   return `XLEN'(a >= b);
    endcase
  endfunction

  function automatic logic [`XLEN-1:0] md_ref(input ex_pkg::md_op_e op,
                                              input logic [`XLEN-1:0] a,
                                              input logic [`XLEN-1:0] b);
    logic [2*`XLEN-1:0] prod;
    prod = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
    case (op)
      ex_pkg::MD_MUL:  return prod[`XLEN-1:0];
      ex_pkg::MD_MULH: return prod[2*`XLEN-1:`XLEN];
      // Zero divisor gives all ones and the dividend
      ex_pkg::MD_DIV:  return (b == '0) ? '1 : a / b;
      default:         return (b == '0) ? a : a % b;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [`XLEN-1:0] got,
                           input logic [`XLEN-1:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // One multiply/divide operation with back-pressure after valid
  task automatic run_md(input ex_pkg::md_op_e op, input logic [`XLEN-1:0] a,
                        input logic [`XLEN-1:0] b, input int hold);
    int lat;
    @(negedge clk_i);
    multdiv_operator_i  = op;
    multdiv_operand_a_i = a;
    multdiv_operand_b_i = b;
    multdiv_ready_id_i  = 1'b0;
    mult_en_i           = (op == ex_pkg::MD_MUL) || (op == ex_pkg::MD_MULH);
    mult_sel_i          = mult_en_i;
    div_en_i            = !mult_en_i;
    div_sel_i           = div_en_i;
    exp_result          = md_ref(op, a, b);
    // Valid stays low until the finish state
    lat = 0;
    do begin
      @(negedge clk_i);
      lat++;
    end while (!ex_valid_o && lat < MD_LATENCY + 4);
    check_val("multdiv latency", lat, MD_LATENCY);
    check_val("result_o", result_o, exp_result);
    md_chk = 1'b1;
    repeat (hold) begin
      @(negedge clk_i);
      check_val("ex_valid_o", `XLEN'(ex_valid_o), 1);
    end
    multdiv_ready_id_i = 1'b1;
    @(negedge clk_i);
    // Back in idle with sel still high
    check_val("ex_valid_o", `XLEN'(ex_valid_o), 0);
    md_chk             = 1'b0;
    mult_en_i          = 1'b0;
    div_en_i           = 1'b0;
    mult_sel_i         = 1'b0;
    div_sel_i          = 1'b0;
    multdiv_ready_id_i = 1'b0;
  endtask

  ////////////////////////////////////////
  // Comparing process and cycle limit
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    if (alu_chk) begin
      check_val("result_o", result_o, exp_result);
      check_val("ex_valid_o", `XLEN'(ex_valid_o), 1);
      check_val("branch_target_o", branch_target_o, exp_target);
      if (chk_adder) begin
        check_val("alu_adder_result_o", alu_adder_result_o, exp_adder);
      end
      if (chk_branch) begin
        check_val("branch_decision_o", `XLEN'(branch_decision_o), `XLEN'(exp_branch));
      end
    end
    if (md_chk) begin
      check_val("result_o", result_o, exp_result);
    end
  end

  always @(negedge clk_i) begin
    if (uut.u_props.assert_failed) begin
      $display("A property of the bound assertion checker failed");
      $display("TESTS FAILED");
      $fatal(1, "Property failure");
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the cycle limit was reached before the tests finished");
      $display("TESTS FAILED");
      $fatal(1, "Cycle limit reached");
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    logic [31:0]      r;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    ex_pkg::alu_op_e  op;
    ex_pkg::md_op_e   mop;
    reset_i             = 1'b1;
    alu_operator_i      = ex_pkg::ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    bt_a_operand_i      = '0;
    bt_b_operand_i      = '0;
    multdiv_operator_i  = ex_pkg::MD_MUL;
    mult_en_i           = 1'b0;
    div_en_i            = 1'b0;
    mult_sel_i          = 1'b0;
    div_sel_i           = 1'b0;
    multdiv_operand_a_i = '0;
    multdiv_operand_b_i = '0;
    multdiv_ready_id_i  = 1'b0;
    alu_chk             = 1'b0;
    md_chk              = 1'b0;
    chk_adder           = 1'b0;
    chk_branch          = 1'b0;
    exp_branch          = 1'b0;
    exp_result          = '0;
    exp_adder           = '0;
    exp_target          = '0;
    repeat (3) @(negedge clk_i);
    reset_i = 1'b0;

    // ALU sweep with every operator first and random ones after
    for (int i = 0; i < ALU_TESTS; i++) begin
      @(negedge clk_i);
      r  = next_rand();
      op = (i < 16) ? ex_pkg::alu_op_e'(i) : ex_pkg::alu_op_e'(r[3:0]);
      a  = next_rand();
      // Equal operands now and then for EQ and NE
      b  = r[4] ? a : next_rand();
      alu_operator_i  = op;
      alu_operand_a_i = a;
      alu_operand_b_i = b;
      bt_a_operand_i  = next_rand();
      bt_b_operand_i  = next_rand();
      exp_result      = alu_ref(op, a, b);
      exp_target      = bt_a_operand_i + bt_b_operand_i;
      exp_adder       = (op == ex_pkg::SUB) ? a - b : a + b;
      chk_adder       = (op == ex_pkg::ADD) || (op == ex_pkg::SUB);
      chk_branch      = (op >= ex_pkg::SLT);
      exp_branch      = exp_result[0];
      alu_chk         = 1'b1;
    end
    @(negedge clk_i);
    alu_chk = 1'b0;

    // Multiply/divide with zero and narrow divisors mixed in
    for (int i = 0; i < MD_TESTS; i++) begin
      r   = next_rand();
      mop = ex_pkg::md_op_e'(r[1:0]);
      a   = next_rand();
      b   = next_rand();
      if (r[5:2] == 4'd0) begin
        b = '0;
      end else if (r[6]) begin
        b = b >> r[11:7];
      end
      run_md(mop, a, b, int'(r[14:12]) % 6);
    end

    if (uut.u_props.assert_failed) begin
      $display("A property of the bound assertion checker failed");
      $display("TESTS FAILED");
      $fatal(1, "Property failure");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== sources.f ====
+incdir+.
ex_pkg.sv
ex_alu.sv
ex_multdiv_slow.sv
ex_block.sv
ex_stage.sv
ex_stage_props.sv
ex_stage_tb.sv
